// File: common/pe_defs.svh
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

// double-precision word and significand
`define PE_DWIDTH 64
`define PE_MANT_W 53

// exponent inside the pipes, one bit more than the IEEE field for headroom
`define PE_EXP_W 12
`define PE_EXP_BIAS 1023

// op code
`define PE_OP_W 2

// input strobe to out1_valid, same for every op
`define PE_LATENCY 57

`endif

// File: common/pe_pkg.sv
`default_nettype none

`include "pe_defs.svh"

package pe_pkg;

    // raw IEEE-754 double
    typedef logic [`PE_DWIDTH-1:0] fp64_t;

    // significand with the hidden one
    typedef logic [`PE_MANT_W-1:0] mant_t;

    // biased or unbiased exponent, signed so under/overflow is visible
    typedef logic signed [`PE_EXP_W-1:0] exp_t;

    typedef enum logic [`PE_OP_W-1:0] {
        OP_PASS_A = 2'd0,   // out1 = inp1
        OP_PASS_B = 2'd1,   // out1 = inp2
        OP_DIV    = 2'd2,   // out1 = inp1 / inp2
        OP_SQRT   = 2'd3    // out1 = sqrt(inp1)
    } pe_op_e;

endpackage

`default_nettype wire

// File: rtl/delay_line.sv
`timescale 1ns/1ns
`default_nettype none

module delay_line #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 57
) (
    input  wire             clk,
    input  wire             rst,
    input  wire [WIDTH-1:0] in_data,
    input  wire             in_valid,
    output logic [WIDTH-1:0] out_data,
    output logic            out_valid
);

    logic [WIDTH-1:0] data_q [DEPTH];
    logic [DEPTH-1:0] valid_q;

    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign out_data  = data_q[DEPTH-1];
    assign out_valid = valid_q[DEPTH-1];

endmodule

`default_nettype wire

// File: pe/fp_div_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module fp_div_pipe
    import pe_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire fp64_t a,
    input  wire fp64_t b,
    input  wire        in_valid,
    output fp64_t      q,
    output logic       out_valid
);

    localparam int FRAC_W = `PE_MANT_W - 1;            // stored fraction bits
    localparam int EF_W   = `PE_DWIDTH - `PE_MANT_W;   // IEEE exponent field
    localparam int QBITS  = `PE_MANT_W + 1;            // one extra bit for ma < mb
    localparam int REM_W  = `PE_MANT_W + 1;

    // stage k holds the state after k quotient bits
    logic [REM_W-1:0] rem   [QBITS];
    mant_t            dvs   [QBITS];
    logic [QBITS-1:0] quo   [QBITS+1];
    logic             sgn   [QBITS+1];
    exp_t             ex    [QBITS+1];
    logic [QBITS:0]   vld;
    logic [REM_W:0]   trial [QBITS];

    logic [FRAC_W-1:0] nrm_frac;
    exp_t              nrm_exp;
    logic              nrm_sgn;
    logic              nrm_vld;

    always_comb begin
        for (int i = 0; i < QBITS; i++) begin
            trial[i] = {1'b0, rem[i]} - {2'b00, dvs[i]};   // msb set means rem < divisor
        end
    end

    always_ff @(posedge clk) begin
        // unpack
        rem[0] <= {1'b0, 1'b1, a[FRAC_W-1:0]};
        dvs[0] <= {1'b1, b[FRAC_W-1:0]};
        quo[0] <= '0;
        sgn[0] <= a[`PE_DWIDTH-1] ^ b[`PE_DWIDTH-1];
        ex[0]  <= exp_t'(a[FRAC_W +: EF_W]) - exp_t'(b[FRAC_W +: EF_W])
                  + exp_t'(`PE_EXP_BIAS);

        // one quotient bit per stage
        for (int i = 0; i < QBITS; i++) begin
            quo[i+1] <= {quo[i][QBITS-2:0], ~trial[i][REM_W]};
            sgn[i+1] <= sgn[i];
            ex[i+1]  <= ex[i];
        end
        for (int i = 0; i < QBITS - 1; i++) begin
            rem[i+1] <= trial[i][REM_W] ? {rem[i][REM_W-2:0], 1'b0}
                                        : {trial[i][REM_W-2:0], 1'b0};
            dvs[i+1] <= dvs[i];
        end

        // normalize, quotient is in [0.5, 2)
        if (quo[QBITS][QBITS-1]) begin
            nrm_frac <= quo[QBITS][QBITS-2:1];
            nrm_exp  <= ex[QBITS];
        end else begin
            nrm_frac <= quo[QBITS][QBITS-3:0];
            nrm_exp  <= ex[QBITS] - exp_t'(1);
        end
        nrm_sgn <= sgn[QBITS];

        // pack, truncated
        q <= {nrm_sgn, nrm_exp[EF_W-1:0], nrm_frac};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld       <= '0;
            nrm_vld   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            vld       <= {vld[QBITS-1:0], in_valid};
            nrm_vld   <= vld[QBITS];
            out_valid <= nrm_vld;
        end
    end

endmodule

`default_nettype wire

// File: pe/fp_sqrt_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module fp_sqrt_pipe
    import pe_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire fp64_t a,
    input  wire        in_valid,
    output fp64_t      r,
    output logic       out_valid
);

    localparam int FRAC_W = `PE_MANT_W - 1;
    localparam int EF_W   = `PE_DWIDTH - `PE_MANT_W;
    localparam int RBITS  = `PE_MANT_W;        // root bits, one per stage
    localparam int RAD_W  = 2 * `PE_MANT_W;    // two radicand bits per root bit
    localparam int REM_W  = `PE_MANT_W + 2;    // remainder never exceeds 2*root
    localparam int CAND_W = REM_W + 2;

    exp_t              ue;   // unbiased input exponent
    logic [RAD_W-1:0]  rad   [RBITS];
    logic [REM_W-1:0]  rem   [RBITS];
    mant_t             root  [RBITS+1];
    exp_t              ex    [RBITS+1];
    logic [RBITS:0]    vld;
    logic [CAND_W-1:0] cand  [RBITS];
    logic [CAND_W:0]   trial [RBITS];

    mant_t             pad_root [2];
    exp_t              pad_exp  [2];
    logic [1:0]        pad_vld;

    assign ue = exp_t'(a[FRAC_W +: EF_W]) - exp_t'(`PE_EXP_BIAS);

    always_comb begin
        for (int i = 0; i < RBITS; i++) begin
            cand[i]  = {rem[i], rad[i][RAD_W-1 -: 2]};              // bring down next pair
            trial[i] = {1'b0, cand[i]} - {3'b000, root[i], 2'b01};  // 4*root + 1
        end
    end

    always_ff @(posedge clk) begin
        // unpack, odd exponent takes one more shift so the halving is exact
        if (ue[0]) begin
            rad[0] <= {1'b1, a[FRAC_W-1:0], {(FRAC_W + 1){1'b0}}};
        end else begin
            rad[0] <= {1'b0, 1'b1, a[FRAC_W-1:0], {FRAC_W{1'b0}}};
        end
        rem[0]  <= '0;
        root[0] <= '0;
        ex[0]   <= (ue >>> 1) + exp_t'(`PE_EXP_BIAS);

        // digit-by-digit root
        for (int i = 0; i < RBITS; i++) begin
            root[i+1] <= {root[i][RBITS-2:0], ~trial[i][CAND_W]};
            ex[i+1]   <= ex[i];
        end
        for (int i = 0; i < RBITS - 1; i++) begin
            rem[i+1] <= trial[i][CAND_W] ? cand[i][REM_W-1:0] : trial[i][REM_W-1:0];
            rad[i+1] <= {rad[i][RAD_W-3:0], 2'b00};
        end

        // pad to the common latency
        pad_root[0] <= root[RBITS];
        pad_root[1] <= pad_root[0];
        pad_exp[0]  <= ex[RBITS];
        pad_exp[1]  <= pad_exp[0];

        // pack, root msb is the hidden one
        r <= {1'b0, pad_exp[1][EF_W-1:0], pad_root[1][FRAC_W-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld       <= '0;
            pad_vld   <= '0;
            out_valid <= 1'b0;
        end else begin
            vld       <= {vld[RBITS-1:0], in_valid};
            pad_vld   <= {pad_vld[0], vld[RBITS]};
            out_valid <= pad_vld[1];
        end
    end

endmodule

`default_nettype wire

// File: pe/pe_result_select.sv
`timescale 1ns/1ns
`default_nettype none

module pe_result_select
    import pe_pkg::*;
(
    input  wire fp64_t pass_a_data,
    input  wire fp64_t pass_b_data,
    input  wire fp64_t div_data,
    input  wire fp64_t sqrt_data,
    input  wire        pass_a_valid,
    input  wire        pass_b_valid,
    input  wire        div_valid,
    input  wire        sqrt_valid,
    output fp64_t      out1,
    output logic       out1_valid
);

    // all paths share one latency, so at most one strobe is expected
    always_comb begin
        out1_valid = 1'b1;
        out1       = pass_a_data;
        case ({pass_a_valid, pass_b_valid, div_valid, sqrt_valid})
            4'b1000: begin
                out1 = pass_a_data;
            end
            4'b0100: begin
                out1 = pass_b_data;
            end
            4'b0010: begin
                out1 = div_data;
            end
            4'b0001: begin
                out1 = sqrt_data;
            end
            default: begin
                out1_valid = 1'b0;   // idle or collision
            end
        endcase
    end

endmodule

`default_nettype wire

// File: pe/pe_type_d.sv
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module pe_type_d
    import pe_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire fp64_t  inp1,
    input  wire fp64_t  inp2,
    input  wire         inp1_valid,
    input  wire         inp2_valid,
    input  wire pe_op_e op,
    output fp64_t       out1,
    output logic        out1_valid
);

    logic  pass_a_go, pass_b_go, div_go, sqrt_go;
    fp64_t pass_a_data, pass_b_data, div_q, sqrt_r;
    logic  pass_a_valid, pass_b_valid, div_valid, sqrt_valid;

    // op decode into launch strobes
    assign pass_a_go = inp1_valid && (op == OP_PASS_A);
    assign pass_b_go = inp2_valid && (op == OP_PASS_B);
    assign div_go    = inp1_valid && inp2_valid && (op == OP_DIV);
    assign sqrt_go   = inp1_valid && inp2_valid && (op == OP_SQRT);   // both strobes required

    delay_line #(.WIDTH(`PE_DWIDTH), .DEPTH(`PE_LATENCY)) u_pass_a (
        .clk       (clk),
        .rst       (rst),
        .in_data   (inp1),
        .in_valid  (pass_a_go),
        .out_data  (pass_a_data),
        .out_valid (pass_a_valid)
    );

    delay_line #(.WIDTH(`PE_DWIDTH), .DEPTH(`PE_LATENCY)) u_pass_b (
        .clk       (clk),
        .rst       (rst),
        .in_data   (inp2),
        .in_valid  (pass_b_go),
        .out_data  (pass_b_data),
        .out_valid (pass_b_valid)
    );

    fp_div_pipe u_div (
        .clk       (clk),
        .rst       (rst),
        .a         (inp1),
        .b         (inp2),
        .in_valid  (div_go),
        .q         (div_q),
        .out_valid (div_valid)
    );

    fp_sqrt_pipe u_sqrt (
        .clk       (clk),
        .rst       (rst),
        .a         (inp1),
        .in_valid  (sqrt_go),
        .r         (sqrt_r),
        .out_valid (sqrt_valid)
    );

    pe_result_select u_sel (
        .pass_a_data  (pass_a_data),
        .pass_b_data  (pass_b_data),
        .div_data     (div_q),
        .sqrt_data    (sqrt_r),
        .pass_a_valid (pass_a_valid),
        .pass_b_valid (pass_b_valid),
        .div_valid    (div_valid),
        .sqrt_valid   (sqrt_valid),
        .out1         (out1),
        .out1_valid   (out1_valid)
    );

endmodule

`default_nettype wire

// File: bench/tb_pe_type_d.sv
`timescale 1ns/1ns
`default_nettype none

`include "pe_defs.svh"

module tb_pe_type_d
    import pe_pkg::*;
();

    typedef struct packed {
        pe_op_e op;
        fp64_t  a;
        fp64_t  b;
        logic   v1;
        logic   v2;
        fp64_t  result;
    } row_t;

    // rows that launch an op: 8 pass-through, 7 divide, 7 root, 6 mixed
    localparam int RESULT_ROWS = 28;

    logic   clk = 1'b0;
    logic   rst;
    fp64_t  inp1;
    fp64_t  inp2;
    logic   inp1_valid;
    logic   inp2_valid;
    pe_op_e op;
    fp64_t  out1;
    logic   out1_valid;

    row_t        table_q[$];
    fp64_t       exp_data_q[$];
    int          exp_cycle_q[$];   // cycle count at which the result must show
    int          cycle = 0;
    int          received = 0;
    logic [31:0] lcg_state;

    pe_type_d pe_type_d_inst (
        .clk        (clk),
        .rst        (rst),
        .inp1       (inp1),
        .inp2       (inp2),
        .inp1_valid (inp1_valid),
        .inp2_valid (inp2_valid),
        .op         (op),
        .out1       (out1),
        .out1_valid (out1_valid)
    );

    initial begin
        forever begin
            #50 clk = 1'b1;
            #50 clk = 1'b0;
        end
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic fp64_t random_word();
        fp64_t w;
        w[63:32] = lcg_next();
        w[31:0]  = lcg_next();
        return w;
    endfunction

    // which strobes launch an op
    function automatic bit strobes_qualify(pe_op_e o, logic v1, logic v2);
        case (o)
            OP_PASS_A: return v1;
            OP_PASS_B: return v2;
            default:   return v1 && v2;   // divide and root need both
        endcase
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] want,
                               input string what);
        if (got !== want) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, want);
            abort_run();
        end
    endtask

    task automatic add_row(pe_op_e o, fp64_t a, fp64_t b, logic v1, logic v2, fp64_t result);
        row_t r;
        r.op     = o;
        r.a      = a;
        r.b      = b;
        r.v1     = v1;
        r.v2     = v2;
        r.result = result;
        table_q.push_back(r);
    endtask

    task automatic load_table();
        fp64_t w1;
        fp64_t w2;
        for (int k = 0; k < 4; k++) begin   // pass-through, random bit patterns
            w1 = random_word();
            w2 = random_word();
            add_row(OP_PASS_A, w1, w2, 1'b1, k[0], w1);
            w1 = random_word();
            w2 = random_word();
            add_row(OP_PASS_B, w1, w2, k[0], 1'b1, w2);
        end
        add_row(OP_DIV, $realtobits(6.0), $realtobits(3.0), 1'b1, 1'b1, $realtobits(2.0));
        add_row(OP_DIV, $realtobits(1.0), $realtobits(4.0), 1'b1, 1'b1, $realtobits(0.25));
        add_row(OP_DIV, $realtobits(-7.5), $realtobits(2.5), 1'b1, 1'b1, $realtobits(-3.0));
        add_row(OP_DIV, $realtobits(3.0), $realtobits(0.75), 1'b1, 1'b1, $realtobits(4.0));
        add_row(OP_DIV, $realtobits(2.25), $realtobits(1.5), 1'b1, 1'b1, $realtobits(1.5));
        add_row(OP_DIV, $realtobits(9.0), $realtobits(6.0), 1'b1, 1'b1, $realtobits(1.5));
        add_row(OP_DIV, $realtobits(10.0), $realtobits(4.0), 1'b1, 1'b1, $realtobits(2.5));
        add_row(OP_SQRT, $realtobits(2.25), 64'h0, 1'b1, 1'b1, $realtobits(1.5));   // odd exp
        add_row(OP_SQRT, $realtobits(16.0), 64'h0, 1'b1, 1'b1, $realtobits(4.0));
        add_row(OP_SQRT, $realtobits(0.25), 64'h0, 1'b1, 1'b1, $realtobits(0.5));
        add_row(OP_SQRT, $realtobits(1024.0), 64'h0, 1'b1, 1'b1, $realtobits(32.0));
        add_row(OP_SQRT, $realtobits(0.0625), 64'h0, 1'b1, 1'b1, $realtobits(0.25));
        add_row(OP_SQRT, $realtobits(9.0), 64'h0, 1'b1, 1'b1, $realtobits(3.0));
        add_row(OP_SQRT, $realtobits(0.5625), 64'h0, 1'b1, 1'b1, $realtobits(0.75));
        // strobe gating, none of these may produce a result
        add_row(OP_DIV, $realtobits(6.0), $realtobits(3.0), 1'b1, 1'b0, 64'h0);
        add_row(OP_DIV, $realtobits(6.0), $realtobits(3.0), 1'b0, 1'b1, 64'h0);
        add_row(OP_SQRT, $realtobits(16.0), 64'h0, 1'b1, 1'b0, 64'h0);
        add_row(OP_SQRT, $realtobits(16.0), 64'h0, 1'b0, 1'b1, 64'h0);
        add_row(OP_PASS_A, random_word(), random_word(), 1'b0, 1'b1, 64'h0);
        add_row(OP_PASS_B, random_word(), random_word(), 1'b1, 1'b0, 64'h0);
        add_row(OP_PASS_A, random_word(), random_word(), 1'b0, 1'b0, 64'h0);
        // mixed ops back to back
        w1 = random_word();
        add_row(OP_PASS_A, w1, random_word(), 1'b1, 1'b1, w1);
        add_row(OP_DIV, $realtobits(8.0), $realtobits(2.0), 1'b1, 1'b1, $realtobits(4.0));
        add_row(OP_SQRT, $realtobits(4.0), random_word(), 1'b1, 1'b1, $realtobits(2.0));
        w2 = random_word();
        add_row(OP_PASS_B, random_word(), w2, 1'b1, 1'b1, w2);
        add_row(OP_DIV, $realtobits(-1.0), $realtobits(-0.5), 1'b1, 1'b1, $realtobits(2.0));
        add_row(OP_SQRT, $realtobits(6.25), 64'h0, 1'b1, 1'b1, $realtobits(2.5));
    endtask

    // receiver, samples away from the rising edge
    always @(negedge clk) begin
        if (out1_valid !== 1'b0 && out1_valid !== 1'b1) begin
            $display("out1_valid is unknown at %0t ns", $time);
            abort_run();
        end else if (out1_valid) begin
            if (rst) begin
                $display("out1_valid went high during reset at %0t ns", $time);
                abort_run();
            end else if (exp_data_q.size() == 0) begin
                $display("unexpected result on out1 at %0t ns", $time);
                abort_run();
            end else begin
                check_value(64'(cycle), 64'(exp_cycle_q[0]), "result cycle");
                check_value(out1, exp_data_q[0], "out1 data");
                void'(exp_data_q.pop_front());
                void'(exp_cycle_q.pop_front());
                received++;
            end
        end else if (exp_cycle_q.size() != 0 && cycle >= exp_cycle_q[0]) begin
            $display("expected result missing on out1 at %0t ns", $time);
            abort_run();
        end
    end

    initial begin
        int wait_cnt;
        rst        = 1'b1;
        inp1       = '0;
        inp2       = '0;
        inp1_valid = 1'b0;
        inp2_valid = 1'b0;
        op         = OP_PASS_A;
        lcg_state  = 32'h5ea9;
        load_table();
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        foreach (table_q[i]) begin
            @(posedge clk);
            #1;
            op         = table_q[i].op;
            inp1       = table_q[i].a;
            inp2       = table_q[i].b;
            inp1_valid = table_q[i].v1;
            inp2_valid = table_q[i].v2;
            if (strobes_qualify(table_q[i].op, table_q[i].v1, table_q[i].v2)) begin
                exp_data_q.push_back(table_q[i].result);
                exp_cycle_q.push_back(cycle + `PE_LATENCY);
            end
        end
        @(posedge clk);
        #1;
        inp1_valid = 1'b0;
        inp2_valid = 1'b0;

        wait_cnt = 0;
        while (exp_data_q.size() != 0 && wait_cnt < 200) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_data_q.size() != 0) begin
            $display("timeout, %0d results never arrived", exp_data_q.size());
            abort_run();
        end else begin
            repeat (70) @(posedge clk);   // quiet tail, catches stray pulses
            check_value(64'(received), 64'(RESULT_ROWS), "result count");
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/pe_pkg.sv
rtl/delay_line.sv
pe/fp_div_pipe.sv
pe/fp_sqrt_pipe.sv
pe/pe_result_select.sv
pe/pe_type_d.sv
bench/tb_pe_type_d.sv

// File: Bender.yml
package:
  name: pe_type_d

export_include_dirs:
  - common

sources:
  - common/pe_pkg.sv
  - rtl/delay_line.sv
  - pe/fp_div_pipe.sv
  - pe/fp_sqrt_pipe.sv
  - pe/pe_result_select.sv
  - pe/pe_type_d.sv
  - target: test
    files:
      - bench/tb_pe_type_d.sv
